/* files.f */
common/exec_pkg.sv
design/alu.sv
divider/div_unit.sv
design/exec_stage.sv
design/exec_top.sv
test/exec_asserts.sv
test/exec_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/exec_tb.sv */
// Execute stage testbench
`timescale 1ns/10ps

module exec_tb import exec_pkg::*; ();

    localparam int XLEN        = 32;
    localparam int SHW         = $clog2(XLEN);
    localparam int ALU_LAT     = 1;         // Edges from driving req to ack
    localparam int DIV_LAT     = XLEN + 3;  // Start pulse, XLEN steps, fix, capture
    localparam int ACK_TIMEOUT = 200;
    localparam int REL_TIMEOUT = 10;
    localparam int CLS_ALU     = 0;
    localparam int CLS_BR      = 1;
    localparam int CLS_DIV     = 2;
    localparam int CLS_MIX     = 3;
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

    localparam exec_op_t ALU_OPS [0:9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                           OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    localparam exec_op_t BR_OPS [0:5]  = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    localparam exec_op_t DIV_OPS [0:3] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    logic            clk;
    logic            rst;
    logic            req;
    exec_op_t        op;
    reg_addr_t       rd_addr;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic            ack;
    logic [XLEN-1:0] result;
    reg_addr_t       rd_addr_out;
    logic            rd_we;
    logic            branch_taken;

    logic [31:0]     rng_state;
    int              err_count;
    int              timeout_count;
    int              issued;
    int              ack_rises;
    logic            ack_seen;
    logic            hung;  // Set on any timeout, stops further traffic

    exec_top #(.XLEN(XLEN)) u_dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .req_i          (req),
        .ack_o          (ack),
        .op_i           (op),
        .rd_addr_i      (rd_addr),
        .opa_i          (opa),
        .opb_i          (opb),
        .result_o       (result),
        .rd_addr_o      (rd_addr_out),
        .rd_we_o        (rd_we),
        .branch_taken_o (branch_taken)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Every completed handshake shows up as one ack rise
    always @(negedge clk) begin
        if (ack && !ack_seen) begin
            ack_rises = ack_rises + 1;
        end
        ack_seen = ack;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Zero, all ones, most negative and one with 1 in 4 odds
    function automatic logic [XLEN-1:0] rand_operand();
        logic [31:0]     pick;
        logic [63:0]     wide;
        logic [XLEN-1:0] val;
        pick = next_rand();
        wide = {next_rand(), next_rand()};
        case (pick[3:0])
            4'd0:    val = '0;
            4'd1:    val = '1;
            4'd2:    val = MIN_VAL;
            4'd3:    val = XLEN'(1);
            default: val = wide[XLEN-1:0];
        endcase
        return val;
    endfunction

    function automatic exec_op_t pick_op(input int cls);
        int       sel;
        exec_op_t chosen;
        sel = (cls == CLS_MIX) ? int'(next_rand() % 32'd3) : cls;
        if (sel == CLS_ALU) begin
            chosen = ALU_OPS[int'(next_rand() % 32'd10)];
        end else if (sel == CLS_BR) begin
            chosen = BR_OPS[int'(next_rand() % 32'd6)];
        end else begin
            chosen = DIV_OPS[int'(next_rand() % 32'd4)];
        end
        return chosen;
    endfunction

    // Reference behavior of one operation
    function automatic void model_op(
        input  exec_op_t        f_op,
        input  logic [XLEN-1:0] a,
        input  logic [XLEN-1:0] b,
        output logic [XLEN-1:0] res,
        output logic            we,
        output logic            taken,
        output int              lat
    );
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic [XLEN-1:0]        uq;
        logic [XLEN-1:0]        ur;
        logic [SHW-1:0]         sh;
        logic                   div_zero;
        logic                   ovf;
        sa       = a;
        sb       = b;
        sh       = b[SHW-1:0];
        div_zero = b == '0;
        ovf      = (a == MIN_VAL) && (b == '1);
        sq       = '0;
        sr       = '0;
        uq       = '0;
        ur       = '0;
        if (!div_zero) begin
            uq = a / b;
            ur = a % b;
            if (!ovf) begin
                sq = sa / sb;  // Truncates toward zero
                sr = sa % sb;
            end
        end
        res   = '0;
        taken = 1'b0;
        we    = !(f_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU});
        lat   = (f_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) ? DIV_LAT : ALU_LAT;
        case (f_op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << sh;
            OP_SRL:  res = a >> sh;
            OP_SRA:  res = sa >>> sh;
            OP_SLT:  res = {{(XLEN-1){1'b0}}, sa < sb};
            OP_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
            OP_BEQ:  taken = a == b;
            OP_BNE:  taken = a != b;
            OP_BLT:  taken = sa < sb;
            OP_BGE:  taken = sa >= sb;
            OP_BLTU: taken = a < b;
            OP_BGEU: taken = a >= b;
            OP_DIV:  res = div_zero ? '1 : (ovf ? a : sq);
            OP_DIVU: res = div_zero ? '1 : uq;
            OP_REM:  res = div_zero ? a : (ovf ? '0 : sr);
            OP_REMU: res = div_zero ? a : ur;
            default: res = '0;
        endcase
    endfunction

    task automatic report_mismatch(input string tag, input string field,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("ERR %0t: %s %s got %h expected %h", $time, tag, field, got, exp);
        err_count = err_count + 1;
    endtask

    // Full four-phase transfer of one operation
    task automatic run_op(input exec_op_t t_op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input int hold);
        logic [XLEN-1:0] exp_res;
        logic            exp_we;
        logic            exp_taken;
        int              exp_lat;
        logic [31:0]     r;
        reg_addr_t       rd;
        int              waited;
        string           tag;
        logic [XLEN-1:0] held_res;
        logic [6:0]      held_wb;
        if (hung) begin
            return;
        end
        model_op(t_op, a, b, exp_res, exp_we, exp_taken, exp_lat);
        r   = next_rand();
        rd  = r[4:0];
        tag = $sformatf("op %b a %h b %h", t_op, a, b);

        @(posedge clk);
        req     <= 1'b1;
        op      <= t_op;
        rd_addr <= rd;
        opa     <= a;
        opb     <= b;
        issued = issued + 1;

        @(negedge clk);  // Outputs sampled mid-cycle
        waited = 0;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!ack) begin
            $display("Timeout at %0t: ack_o never rose for %s", $time, tag);
            timeout_count = timeout_count + 1;
            hung = 1'b1;
            req <= 1'b0;
            return;
        end
        if (waited != exp_lat) begin
            report_mismatch(tag, "ack latency", 64'(waited), 64'(exp_lat));
        end
        if (result !== exp_res) begin
            report_mismatch(tag, "result_o", 64'(result), 64'(exp_res));
        end
        if (rd_we !== exp_we) begin
            report_mismatch(tag, "rd_we_o", 64'(rd_we), 64'(exp_we));
        end
        if (branch_taken !== exp_taken) begin
            report_mismatch(tag, "branch_taken_o", 64'(branch_taken), 64'(exp_taken));
        end
        if (rd_addr_out !== rd) begin
            report_mismatch(tag, "rd_addr_o", 64'(rd_addr_out), 64'(rd));
        end

        held_res = result;
        held_wb  = {rd_addr_out, rd_we, branch_taken};
        repeat (hold) begin
            @(posedge clk);
            opa     <= rand_operand();  // Free to change once ack is seen
            opb     <= rand_operand();
            rd_addr <= ~rd;
            @(negedge clk);
            if (!ack) begin
                report_mismatch(tag, "ack_o during hold", 64'(ack), 64'd1);
            end
            if (result !== held_res) begin
                report_mismatch(tag, "result_o during hold", 64'(result), 64'(held_res));
            end
            if ({rd_addr_out, rd_we, branch_taken} !== held_wb) begin
                report_mismatch(tag, "rd fields during hold",
                                64'({rd_addr_out, rd_we, branch_taken}), 64'(held_wb));
            end
        end

        @(posedge clk);
        req <= 1'b0;
        opa <= rand_operand();  // Stale operands must not matter now
        opb <= rand_operand();
        @(negedge clk);
        waited = 0;
        while (ack && waited < REL_TIMEOUT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (ack) begin
            $display("Timeout at %0t: ack_o stayed high after req_i dropped for %s", $time, tag);
            timeout_count = timeout_count + 1;
            hung = 1'b1;
        end else if (waited != 1) begin
            report_mismatch(tag, "ack release latency", 64'(waited), 64'd1);
        end
    endtask

    task automatic run_batch(input int count, input int cls, input int max_hold,
                             input int max_gap);
        exec_op_t        b_op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0]     r;
        int              hold;
        int              gap;
        for (int i = 0; i < count && !hung; i++) begin
            b_op = pick_op(cls);
            a    = rand_operand();
            b    = rand_operand();
            r    = next_rand();
            if (r[2:0] == 3'd0) begin
                b = a;  // Equal operands now and then
            end
            hold = (max_hold > 0) ? int'(r[15:8]) % (max_hold + 1) : 0;
            gap  = (max_gap > 0) ? int'(r[23:16]) % (max_gap + 1) : 0;
            repeat (gap) @(posedge clk);
            run_op(b_op, a, b, hold);
        end
    endtask

    // Divide by zero and signed overflow for every divide code
    task automatic run_div_corners();
        for (int i = 0; i < 4; i++) begin
            run_op(DIV_OPS[i], rand_operand(), '0, 0);
            run_op(DIV_OPS[i], MIN_VAL, '1, 0);
            run_op(DIV_OPS[i], '0, '0, 1);
        end
    endtask

    initial begin
        rng_state     = 32'h9bdcbe72;
        err_count     = 0;
        timeout_count = 0;
        issued        = 0;
        ack_rises     = 0;
        ack_seen      = 1'b0;
        hung          = 1'b0;
        rst           = 1'b1;
        req           = 1'b0;
        op            = OP_ADD;
        rd_addr       = '0;
        opa           = '0;
        opb           = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        if ({ack, rd_we, branch_taken} !== 3'b000) begin
            report_mismatch("reset", "ack/we/taken", 64'({ack, rd_we, branch_taken}), 64'd0);
        end
        if (result !== '0) begin
            report_mismatch("reset", "result_o", 64'(result), 64'd0);
        end

        run_batch(400, CLS_ALU, 0, 2);
        run_batch(150, CLS_BR, 0, 2);
        run_div_corners();
        run_batch(80, CLS_DIV, 0, 2);
        run_batch(40, CLS_MIX, 8, 0);   // Long holds
        run_batch(200, CLS_MIX, 2, 4);  // Mixed traffic with idle gaps

        @(posedge clk);
        if (!hung && ack_rises != issued) begin
            report_mismatch("summary", "ack count", 64'(ack_rises), 64'(issued));
        end
        $display("Operations: %0d, errors: %0d, timeouts: %0d",
                 issued, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/exec_asserts.sv */
// Execute handshake assertions
`timescale 1ns/10ps

module exec_asserts import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input logic            clk_i,
    input logic            rst_i,
    input logic            req_i,
    input exec_op_t        op_i,
    input logic            ack_o,
    input logic [XLEN-1:0] result_o,
    input reg_addr_t       rd_addr_o,
    input logic            rd_we_o,
    input logic            branch_taken_o
);

    // ack_o only answers a live request
    ack_needs_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> req_i
    ) else $error("ack_o rose while req_i was low");

    // Write-back frozen for the whole ack phase
    hold_outputs: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ack_o && $past(ack_o) |-> $stable(result_o) && $stable(rd_addr_o)
            && $stable(rd_we_o) && $stable(branch_taken_o)
    ) else $error("write-back outputs changed while ack_o was high");

    // Branch class never writes a register, taken or not
    no_branch_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ack_o && (op_i[4:3] == CLASS_BRANCH) |-> !rd_we_o
    ) else $error("rd_we_o high for a branch operation");

    quiet_in_reset: assert property (
        @(posedge clk_i) rst_i && $past(rst_i) |-> !ack_o
    ) else $error("ack_o high during reset");

endmodule

bind exec_stage exec_asserts #(.XLEN(XLEN)) u_asserts (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .op_i           (op_i),
    .ack_o          (ack_o),
    .result_o       (result_o),
    .rd_addr_o      (rd_addr_o),
    .rd_we_o        (rd_we_o),
    .branch_taken_o (branch_taken_o)
);

/* design/exec_top.sv */
// Integer execute stage top level
`timescale 1ns/10ps

module exec_top import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            req_i,
    output logic            ack_o,
    input  exec_op_t        op_i,
    input  reg_addr_t       rd_addr_i,
    input  logic [XLEN-1:0] opa_i,       // Register or immediate, already chosen
    input  logic [XLEN-1:0] opb_i,
    output logic [XLEN-1:0] result_o,
    output reg_addr_t       rd_addr_o,
    output logic            rd_we_o,
    output logic            branch_taken_o
);

    logic [XLEN-1:0] alu_result;
    logic            alu_branch_taken;
    logic [XLEN-1:0] div_result;
    logic            div_done;
    logic            div_start;

    alu #(.XLEN(XLEN)) u_alu (
        .op_i           (op_i),
        .opa_i          (opa_i),
        .opb_i          (opb_i),
        .result_o       (alu_result),
        .branch_taken_o (alu_branch_taken)
    );

    div_unit #(.XLEN(XLEN)) u_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (op_i),
        .dividend_i (opa_i),
        .divisor_i  (opb_i),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    // Handshake, unit select and write-back
    exec_stage #(.XLEN(XLEN)) u_stage (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .req_i              (req_i),
        .op_i               (op_i),
        .rd_addr_i          (rd_addr_i),
        .alu_result_i       (alu_result),
        .alu_branch_taken_i (alu_branch_taken),
        .div_result_i       (div_result),
        .div_done_i         (div_done),
        .ack_o              (ack_o),
        .div_start_o        (div_start),
        .result_o           (result_o),
        .rd_addr_o          (rd_addr_o),
        .rd_we_o            (rd_we_o),
        .branch_taken_o     (branch_taken_o)
    );

endmodule

/* design/exec_stage.sv */
// Execute handshake and write-back register
`timescale 1ns/10ps

module exec_stage import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            req_i,
    input  exec_op_t        op_i,
    input  reg_addr_t       rd_addr_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            alu_branch_taken_i,
    input  logic [XLEN-1:0] div_result_i,
    input  logic            div_done_i,
    output logic            ack_o,
    output logic            div_start_o,
    output logic [XLEN-1:0] result_o,
    output reg_addr_t       rd_addr_o,
    output logic            rd_we_o,
    output logic            branch_taken_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DIV,
        ACK,
        RELEASE
    } hs_state_t;

    hs_state_t state_q;
    op_class_t op_class;
    logic      is_branch;

    assign op_class  = op_class_of(op_i);
    assign is_branch = op_class == CLASS_BRANCH;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q        <= IDLE;
            ack_o          <= 1'b0;
            div_start_o    <= 1'b0;
            result_o       <= '0;
            rd_addr_o      <= '0;
            rd_we_o        <= 1'b0;
            branch_taken_o <= 1'b0;
        end else begin
            div_start_o <= 1'b0;  // Single-cycle pulse
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        rd_addr_o <= rd_addr_i;
                        if (op_class == CLASS_DIV) begin
                            div_start_o <= 1'b1;
                            state_q     <= WAIT_DIV;
                        end else begin
                            // ALU output is already settled from the held operands
                            result_o       <= is_branch ? '0 : alu_result_i;
                            rd_we_o        <= !is_branch;
                            branch_taken_o <= is_branch & alu_branch_taken_i;
                            ack_o          <= 1'b1;
                            state_q        <= ACK;
                        end
                    end
                end
                WAIT_DIV: begin
                    if (div_done_i) begin
                        result_o       <= div_result_i;
                        rd_we_o        <= 1'b1;
                        branch_taken_o <= 1'b0;
                        ack_o          <= 1'b1;
                        state_q        <= ACK;
                    end
                end
                ACK: begin
                    // Outputs frozen until the issuer lets go
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= RELEASE;
                    end
                end
                RELEASE: begin
                    state_q <= IDLE;  // Issuer sees ack low first
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

/* divider/div_unit.sv */
// Radix-2 iterative divider
`timescale 1ns/10ps

module div_unit import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            start_i,
    input  exec_op_t        op_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic [XLEN-1:0] result_o,
    output logic            done_o
);

    localparam int CW = $clog2(XLEN);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_t;

    div_state_t      state_q;
    logic [CW-1:0]   count_q;
    logic [XLEN-1:0] quo_q;   // Dividend shifts out, quotient shifts in
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvsr_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            rem_sel_q;
    logic            div_zero_q;
    logic            ovf_q;

    logic            is_signed;
    logic            sign_a;
    logic            sign_b;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN:0]   trial;
    logic [XLEN-1:0] diff;
    logic            trial_ge;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    assign is_signed = !op_i[0];
    assign sign_a    = is_signed & dividend_i[XLEN-1];
    assign sign_b    = is_signed & divisor_i[XLEN-1];
    assign abs_a     = sign_a ? -dividend_i : dividend_i;
    assign abs_b     = sign_b ? -divisor_i : divisor_i;

    // One restoring step
    assign trial    = {rem_q, quo_q[XLEN-1]};
    assign diff     = trial[XLEN-1:0] - dvsr_q;
    assign trial_ge = trial >= {1'b0, dvsr_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        count_q <= '0;
                    end
                end
                RUN: begin
                    count_q <= count_q + CW'(1);
                    if (count_q == CW'(XLEN-1)) begin
                        state_q <= FIX;
                    end
                end
                FIX:     state_q <= IDLE;  // Result held until next start
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            quo_q      <= abs_a;
            rem_q      <= '0;
            dvsr_q     <= abs_b;
            neg_quo_q  <= sign_a ^ sign_b;
            neg_rem_q  <= sign_a;  // Remainder follows the dividend
            rem_sel_q  <= op_i[1];
            div_zero_q <= divisor_i == '0;
            ovf_q      <= sign_a && (abs_a == {1'b1, {(XLEN-1){1'b0}}}) && (&divisor_i);
        end else if (state_q == RUN) begin
            rem_q <= trial_ge ? diff : trial[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], trial_ge};
        end
    end

    // Sign correction and the RISC-V special cases
    always_comb begin
        quo_fix = neg_quo_q ? -quo_q : quo_q;
        rem_fix = neg_rem_q ? -rem_q : rem_q;
        if (div_zero_q) begin
            quo_fix = '1;
        end else if (ovf_q) begin
            quo_fix = {1'b1, {(XLEN-1){1'b0}}};  // Equal to the dividend
            rem_fix = '0;
        end
    end

    assign result_o = rem_sel_q ? rem_fix : quo_fix;
    assign done_o   = state_q == FIX;

endmodule

/* design/alu.sv */
// Integer ALU and branch compare
`timescale 1ns/10ps

module alu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  exec_op_t        op_i,
    input  logic [XLEN-1:0] opa_i,
    input  logic [XLEN-1:0] opb_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           lt_s;
    logic           lt_u;
    logic           eq;

    assign shamt = opb_i[SHW-1:0];  // Only the low bits count
    assign lt_s  = $signed(opa_i) < $signed(opb_i);
    assign lt_u  = opa_i < opb_i;
    assign eq    = opa_i == opb_i;

    // Write-back value
    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = opa_i + opb_i;
            end
            OP_SUB: begin
                result_o = opa_i - opb_i;
            end
            OP_AND:  result_o = opa_i & opb_i;
            OP_OR:   result_o = opa_i | opb_i;
            OP_XOR:  result_o = opa_i ^ opb_i;
            OP_SLL:  result_o = opa_i << shamt;
            OP_SRL:  result_o = opa_i >> shamt;
            OP_SRA:  result_o = $signed(opa_i) >>> shamt;  // Keeps the sign bit
            OP_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s};
            end
            OP_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            default: begin
                result_o = '0;  // Branches, divides and unused codes
            end
        endcase
    end

    // Branch condition
    always_comb begin
        case (op_i)
            OP_BEQ:  branch_taken_o = eq;
            OP_BNE:  branch_taken_o = !eq;
            OP_BLT:  branch_taken_o = lt_s;
            OP_BGE:  branch_taken_o = !lt_s;
            OP_BLTU: branch_taken_o = lt_u;
            OP_BGEU: branch_taken_o = !lt_u;
            // Anything else must never look like a taken branch
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

/* common/exec_pkg.sv */
// Execute stage shared definitions
package exec_pkg;

    typedef logic [4:0] exec_op_t;   // {class, function}
    typedef logic [1:0] op_class_t;
    typedef logic [4:0] reg_addr_t;  // Destination register

    localparam op_class_t CLASS_ALU    = 2'b00;  // Single-cycle ALU
    localparam op_class_t CLASS_BRANCH = 2'b01;  // Compare only, no write-back
    localparam op_class_t CLASS_DIV    = 2'b10;  // Iterative divider

    // Arithmetic, logic and shifts
    localparam exec_op_t OP_ADD  = 5'b00_000;
    localparam exec_op_t OP_SUB  = 5'b00_001;
    localparam exec_op_t OP_AND  = 5'b00_010;
    localparam exec_op_t OP_OR   = 5'b00_011;
    localparam exec_op_t OP_XOR  = 5'b00_100;
    localparam exec_op_t OP_SLL  = 5'b00_101;
    localparam exec_op_t OP_SRL  = 5'b00_110;
    localparam exec_op_t OP_SRA  = 5'b00_111;

    // Set-less-than spills into the spare 11 field and still counts as ALU
    localparam exec_op_t OP_SLT  = 5'b11_010;
    localparam exec_op_t OP_SLTU = 5'b11_011;

    // Branch low bits equal funct3
    localparam exec_op_t OP_BEQ  = 5'b01_000;
    localparam exec_op_t OP_BNE  = 5'b01_001;
    localparam exec_op_t OP_BLT  = 5'b01_100;
    localparam exec_op_t OP_BGE  = 5'b01_101;
    localparam exec_op_t OP_BLTU = 5'b01_110;
    localparam exec_op_t OP_BGEU = 5'b01_111;

    // Divide: bit 0 selects unsigned, bit 1 selects remainder
    localparam exec_op_t OP_DIV  = 5'b10_100;
    localparam exec_op_t OP_DIVU = 5'b10_101;
    localparam exec_op_t OP_REM  = 5'b10_110;
    localparam exec_op_t OP_REMU = 5'b10_111;

    // Unit class of an operation code
    function automatic op_class_t op_class_of(input exec_op_t op);
        op_class_t cls;
        cls = op[4:3];
        if (cls == 2'b11) begin
            cls = CLASS_ALU;  // SLT and SLTU live here
        end
        return cls;
    endfunction

endpackage
